// ==== pov.f ====
common/pov_pkg.sv
pov_spi/pov_spi_rx.sv
hdl/pov_motion.sv
hdl/pov_state.sv
hdl/pov_top.sv
tb/pov_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = pov_tb
LINT_TOP   = pov_top
FILELIST   = pov.f
BUILD_DIR  = obj_dir
LOG        = sim.log
VFLAGS     = --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only -Wall --timing --top-module $(LINT_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The simulator exit code is lost in the pipe, so the log decides
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "test passed" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/pov_tb.sv ====
`timescale 1ns/1ps

module pov_tb import pov_pkg::*; ();

  // Fixed seed so that every run sends the same frames
  localparam logic [31:0] LFSR_SEED = 32'h4b332e6e;

  // Cycle limits for the wait loops
  localparam int PENDING_TIMEOUT = 200;
  localparam int CHECK_TIMEOUT   = 10;

  // Clock cycles spent in each half of one SCLK period
  localparam int SCLK_HALF = 4;

  // Start-up view in Q12.12. The player stands at (1.5,1.5) and faces (0,1)
  // with a view plane of (-0.5,0)
  localparam pov_t START_VIEW = {
    24'h001800, 24'h001800,
    24'h000000, 24'h001000,
    24'hfff800, 24'h000000
  };

  // DUT pins
  logic  clk;
  logic  reset;
  logic  sclk;
  logic  ss_n;
  logic  mosi;
  logic  load_if_ready;
  logic  move_fwd;
  logic  move_back;
  pov_t  pov;
  logic  frame_pending;

  // Expected state that the checker compares against
  pov_t  exp_pov;
  logic  exp_pending;

  // Check requests from the stimulus and checks finished by the checker
  int    check_req = 0;
  int    checks_done = 0;

  // Random source and a copy of the last complete frame sent
  logic [31:0] lfsr_state;
  pov_t        pending_copy;

  pov_top pov_top_i (
    .clk           (clk),
    .reset         (reset),
    .sclk          (sclk),
    .ss_n          (ss_n),
    .mosi          (mosi),
    .load_if_ready (load_if_ready),
    .move_fwd      (move_fwd),
    .move_back     (move_back),
    .pov           (pov),
    .frame_pending (frame_pending)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Expected pov after one load. A pending frame goes live as a whole.
  // Otherwise the player moves by one eighth of the facing vector,
  // rounded toward minus infinity, and the sums wrap at 24 bits
  function automatic pov_t next_pov(input pov_t cur, input logic pending,
                                    input pov_t frame, input logic fwd,
                                    input logic back);
    pov_t   result;
    fixed_t face_x;
    fixed_t face_y;
    fixed_t delta_x;
    fixed_t delta_y;
    result = cur;
    if (pending) begin
      result = frame;
    end else begin
      face_x  = cur.facing.x;
      face_y  = cur.facing.y;
      delta_x = face_x >>> MOVE_SHIFT;
      delta_y = face_y >>> MOVE_SHIFT;
      if (fwd && !back) begin
        result.player.x = cur.player.x + delta_x;
        result.player.y = cur.player.y + delta_y;
      end else if (back && !fwd) begin
        result.player.x = cur.player.x - delta_x;
        result.player.y = cur.player.y - delta_y;
      end
    end
    return result;
  endfunction

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [23:0] actual,
                               input logic [23:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("FAILED %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  // Compare on the falling edge half a cycle away from any DUT update
  always @(negedge clk) begin
    if (checks_done != check_req) begin
      compare_value("pov.player.x", pov.player.x, exp_pov.player.x);
      compare_value("pov.player.y", pov.player.y, exp_pov.player.y);
      compare_value("pov.facing.x", pov.facing.x, exp_pov.facing.x);
      compare_value("pov.facing.y", pov.facing.y, exp_pov.facing.y);
      compare_value("pov.vplane.x", pov.vplane.x, exp_pov.vplane.x);
      compare_value("pov.vplane.y", pov.vplane.y, exp_pov.vplane.y);
      compare_value("frame_pending", {23'b0, frame_pending}, {23'b0, exp_pending});
      checks_done = checks_done + 1;
    end
  end

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  // Hand the expected state to the checker and wait until it has compared
  task automatic expect_state(input pov_t want, input logic want_pending);
    bit done;
    done = 1'b0;
    exp_pov     <= want;
    exp_pending <= want_pending;
    check_req   <= check_req + 1;
    for (int i = 0; i < CHECK_TIMEOUT; i++) begin
      @(posedge clk);
      if (checks_done == check_req) begin
        done = 1'b1;
        break;
      end
    end
    if (!done) begin
      stop_with_error("The checker did not finish its comparison in time");
    end
  endtask

  task automatic take_random(input int count, output logic [FRAME_BITS-1:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[FRAME_BITS-2:0], lfsr_state[0]};
    end
  endtask

  task automatic select_slave();
    sclk <= 1'b0;
    ss_n <= 1'b0;
    idle_cycles(SCLK_HALF);
  endtask

  // Long enough high time for the synchroniser and the counter to clear
  task automatic release_slave();
    ss_n <= 1'b1;
    mosi <= 1'b0;
    idle_cycles(2 * SCLK_HALF);
  endtask

  // Send the first count bits of data MSB first. Mosi moves with the fall
  task automatic shift_out_bits(input pov_t data, input int count);
    logic [FRAME_BITS-1:0] shreg;
    shreg = data;
    for (int i = 0; i < count; i++) begin
      sclk <= 1'b0;
      mosi <= shreg[FRAME_BITS-1];
      shreg = shreg << 1;
      idle_cycles(SCLK_HALF);
      sclk <= 1'b1;
      idle_cycles(SCLK_HALF);
    end
    sclk <= 1'b0;
    idle_cycles(SCLK_HALF);
  endtask

  task automatic send_frame(input pov_t data);
    select_slave();
    shift_out_bits(data, FRAME_BITS);
    release_slave();
  endtask

  task automatic wait_for_pending();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < PENDING_TIMEOUT; i++) begin
      @(negedge clk);
      if (frame_pending) begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen) begin
      stop_with_error($sformatf("frame_pending did not rise within %0d clock cycles",
                                PENDING_TIMEOUT));
    end
    @(posedge clk);
  endtask

  // One load strobe with the given move levels, then check the result.
  // Any load leaves nothing pending, since no frame completes meanwhile
  task automatic apply_load(input logic fwd, input logic back);
    pov_t want;
    want = next_pov(exp_pov, exp_pending, pending_copy, fwd, back);
    move_fwd      <= fwd;
    move_back     <= back;
    load_if_ready <= 1'b1;
    @(posedge clk);
    load_if_ready <= 1'b0;
    move_fwd      <= 1'b0;
    move_back     <= 1'b0;
    expect_state(want, 1'b0);
  endtask

  initial begin
    logic [FRAME_BITS-1:0] bits;
    pov_t                  first_frame;
    pov_t                  second_frame;
    int                    cut;

    reset         = 1'b1;
    sclk          = 1'b0;
    ss_n          = 1'b1;
    mosi          = 1'b0;
    load_if_ready = 1'b0;
    move_fwd      = 1'b0;
    move_back     = 1'b0;
    exp_pov       = START_VIEW;
    exp_pending   = 1'b0;
    lfsr_state    = LFSR_SEED;
    pending_copy  = START_VIEW;

    idle_cycles(8);
    reset <= 1'b0;

    // Start-up view straight out of reset
    expect_state(START_VIEW, 1'b0);

    // Every move combination on the start-up view
    apply_load(1'b1, 1'b0);
    apply_load(1'b0, 1'b1);
    apply_load(1'b1, 1'b1);
    apply_load(1'b0, 1'b0);

    // A random frame stays pending until the load, and wins over movement
    take_random(FRAME_BITS, bits);
    first_frame = pov_t'(bits);
    send_frame(first_frame);
    pending_copy = first_frame;
    wait_for_pending();
    expect_state(exp_pov, 1'b1);
    idle_cycles(5);
    expect_state(exp_pov, 1'b1);
    apply_load(1'b1, 1'b0);

    // Movement with a random facing vector, so signs and wrapping show up
    apply_load(1'b1, 1'b0);
    apply_load(1'b0, 1'b1);
    apply_load(1'b1, 1'b1);
    apply_load(1'b0, 1'b0);
    for (int n = 0; n < 12; n++) begin
      take_random(2, bits);
      apply_load(bits[1], bits[0]);
    end

    // Broken-off frame followed by a complete one
    take_random(8, bits);
    cut = 1 + (int'(bits[7:0]) % (FRAME_BITS - 1));
    take_random(FRAME_BITS, bits);
    select_slave();
    shift_out_bits(pov_t'(bits), cut);
    release_slave();
    expect_state(exp_pov, 1'b0);
    take_random(FRAME_BITS, bits);
    second_frame = pov_t'(bits);
    send_frame(second_frame);
    pending_copy = second_frame;
    wait_for_pending();
    expect_state(exp_pov, 1'b1);
    apply_load(1'b0, 1'b1);

    // Two frames under one select where only the newer one goes live
    take_random(FRAME_BITS, bits);
    first_frame = pov_t'(bits);
    take_random(FRAME_BITS, bits);
    second_frame = pov_t'(bits);
    select_slave();
    shift_out_bits(first_frame, FRAME_BITS);
    shift_out_bits(second_frame, FRAME_BITS);
    release_slave();
    pending_copy = second_frame;
    wait_for_pending();
    expect_state(exp_pov, 1'b1);
    apply_load(1'b0, 1'b0);

    idle_cycles(2);
    $display("test passed");
    $finish;
  end

endmodule

// ==== hdl/pov_top.sv ====
`timescale 1ns/1ps

module pov_top import pov_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  input  logic load_if_ready,
  input  logic move_fwd,
  input  logic move_back,
  output pov_t pov,
  output logic frame_pending
);

  // Frame from the SPI receiver, valid while frame_done is high
  pov_t  frame;
  logic  frame_done;

  // Player position that a movement load would take
  vec2_t step_player;

  // SPI slave, brings complete frames into the clk domain
  pov_spi_rx pov_spi_rx_i (
    .clk        (clk),
    .reset      (reset),
    .sclk       (sclk),
    .ss_n       (ss_n),
    .mosi       (mosi),
    .frame      (frame),
    .frame_done (frame_done)
  );

  // Movement works from the live state, not from any pending frame
  pov_motion pov_motion_i (
    .pov         (pov),
    .move_fwd    (move_fwd),
    .move_back   (move_back),
    .step_player (step_player)
  );

  // Owns the live registers and picks between SPI and movement
  pov_state pov_state_i (
    .clk           (clk),
    .reset         (reset),
    .load_if_ready (load_if_ready),
    .frame         (frame),
    .frame_done    (frame_done),
    .step_player   (step_player),
    .pov           (pov),
    .frame_pending (frame_pending)
  );

endmodule

// ==== hdl/pov_state.sv ====
`timescale 1ns/1ps

module pov_state import pov_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  load_if_ready,
  input  pov_t  frame,
  input  logic  frame_done,
  input  vec2_t step_player,
  output pov_t  pov,
  output logic  frame_pending
);

  // Last complete SPI frame that has not been loaded yet
  pov_t pending_frame;

  // Load decisions for this cycle
  logic load_frame;
  logic load_step;

  // A pending SPI frame always wins over movement at a load
  assign load_frame = load_if_ready && frame_pending;

  // Movement is applied only when there is no frame waiting
  assign load_step = load_if_ready && !frame_pending;

  // Capture every completed frame. A newer frame overwrites an older one
  // that was never loaded, since the host has no back-pressure.
  // The buffer is only read while frame_pending is set, so it needs no
  // reset value
  always_ff @(posedge clk) begin
    if (frame_done) begin
      pending_frame <= frame;
    end
  end

  // Pending flag. A frame that completes in the same cycle as a load
  // must stay pending, so the set takes priority over the clear
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_pending <= 1'b0;
    end else if (frame_done) begin
      frame_pending <= 1'b1;
    end else if (load_frame) begin
      frame_pending <= 1'b0;
    end
  end

  // Live point of view registers, updated only at the load strobe that
  // the renderer raises once per video frame
  always_ff @(posedge clk) begin
    if (reset) begin
      pov <= POV_RESET;
    end else if (load_frame) begin
      // Whole frame goes live at once, including facing and view plane
      pov <= pending_frame;
    end else if (load_step) begin
      // Movement only touches the player position
      pov.player <= step_player;
    end
  end

  // In the cycle where a load and frame_done coincide, the older buffered
  // frame is what goes live above, since pending_frame is only replaced on
  // the same edge. The new frame then waits for the next load

endmodule

// ==== hdl/pov_motion.sv ====
`timescale 1ns/1ps

module pov_motion import pov_pkg::*; (
  input  pov_t  pov,
  input  logic  move_fwd,
  input  logic  move_back,
  output vec2_t step_player
);

  // Local copies of the fields as fixed_t, so the shifts below are
  // arithmetic and keep the sign of the facing vector
  fixed_t face_x;
  fixed_t face_y;
  fixed_t pos_x;
  fixed_t pos_y;

  // One movement step, a fraction of the facing vector
  fixed_t step_x;
  fixed_t step_y;

  // Candidate positions for both directions
  fixed_t fwd_x;
  fixed_t fwd_y;
  fixed_t back_x;
  fixed_t back_y;

  assign face_x = pov.facing.x;
  assign face_y = pov.facing.y;
  assign pos_x  = pov.player.x;
  assign pos_y  = pov.player.y;

  // Shift right by MOVE_SHIFT, i.e. one eighth of the facing vector
  assign step_x = face_x >>> MOVE_SHIFT;
  assign step_y = face_y >>> MOVE_SHIFT;

  // Sums are kept at 24 bits and simply wrap
  assign fwd_x  = pos_x + step_x;
  assign fwd_y  = pos_y + step_y;
  assign back_x = pos_x - step_x;
  assign back_y = pos_y - step_y;

  // Pick the new position from the move controls. Pressing both
  // controls cancels out, as does pressing neither
  always_comb begin
    case ({move_fwd, move_back})
      2'b10: begin
        step_player.x = fwd_x;
        step_player.y = fwd_y;
      end
      2'b01: begin
        step_player.x = back_x;
        step_player.y = back_y;
      end
      default: begin
        step_player.x = pos_x;
        step_player.y = pos_y;
      end
    endcase
  end

  // The result only becomes live when pov_state takes it at a load
  // strobe with no SPI frame pending

endmodule

// ==== pov_spi/pov_spi_rx.sv ====
`timescale 1ns/1ps

module pov_spi_rx import pov_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  output pov_t frame,
  output logic frame_done
);

  // Synchroniser stages for the asynchronous pins. SCLK gets a third stage
  // so that stages 2 and 3 can be compared for an edge
  logic [2:0] sclk_sync;
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;

  // Pin values as seen in the clk domain
  logic sclk_rise;
  logic ss_active;
  logic mosi_s;

  // Frame reception state
  bit_count_t             bit_count;
  logic                   last_bit;
  logic                   take_bit;
  logic [FRAME_BITS-1:0]  shift_reg;

  // The pins are plain shift chains and carry no reset. They fill from the
  // pins within three cycles, well inside any reset pulse
  always_ff @(posedge clk) begin
    sclk_sync <= {sclk_sync[1:0], sclk};
  end

  always_ff @(posedge clk) begin
    ss_sync <= {ss_sync[0], ss_n};
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], mosi};
  end

  // A rising SCLK edge shows as 0 in stage 3 and 1 in stage 2
  assign sclk_rise = (sclk_sync[2:1] == 2'b01);

  // Slave select is active low
  assign ss_active = ~ss_sync[1];

  // MOSI is stable around the SCLK rise, so the second stage is enough
  assign mosi_s = mosi_sync[1];

  // A bit is taken on every SCLK rise while the slave is selected
  assign take_bit = ss_active && sclk_rise;

  // Position 143 holds the final bit of a frame (vplaneY LSB)
  assign last_bit = (bit_count == bit_count_t'(FRAME_BITS - 1));

  // Bit counter. It stays at zero while SS is high, which throws away any
  // partial frame. After the last bit it wraps so that the host can send
  // frames back to back under one SS low
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_count <= '0;
    end else if (!ss_active) begin
      bit_count <= '0;
    end else if (sclk_rise) begin
      if (last_bit) begin
        bit_count <= '0;
      end else begin
        bit_count <= bit_count + 1'b1;
      end
    end
  end

  // Frame data shifts in MSB first, so the first bit ends up at the top
  always_ff @(posedge clk) begin
    if (take_bit) begin
      shift_reg <= {shift_reg[FRAME_BITS-2:0], mosi_s};
    end
  end

  // Pulse for one cycle once the last bit of a frame has been shifted in.
  // The next SCLK rise is at least three cycles away, so the shift
  // register still holds the complete frame while this pulse is high
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= take_bit && last_bit;
    end
  end

  // The shift register layout is the pov_t layout
  assign frame = pov_t'(shift_reg);

endmodule

// ==== common/pov_pkg.sv ====
package pov_pkg;

  // Fixed-point format shared by every coordinate in the point of view
  localparam int unsigned FIXED_BITS = 24;

  // Number of fraction bits, so one unit is 2^12
  localparam int unsigned FRAC_BITS = 12;

  // A signed Q12.12 value
  typedef logic signed [FIXED_BITS-1:0] fixed_t;

  // Two-component vector, x sits in the upper half
  typedef struct packed {
    fixed_t x;
    fixed_t y;
  } vec2_t;

  // Full point of view. The field order matches the SPI frame order,
  // so playerX arrives first, MSB first, and vplaneY arrives last
  typedef struct packed {
    vec2_t player;
    vec2_t facing;
    vec2_t vplane;
  } pov_t;

  // Length of one SPI frame, one bit for every bit of pov_t
  localparam int unsigned FRAME_BITS = 144;

  // Bit position within a frame, wide enough to count to FRAME_BITS
  typedef logic [7:0] bit_count_t;

  // Movement per load is the facing vector shifted right by this amount,
  // which gives one eighth of the facing vector
  localparam int unsigned MOVE_SHIFT = 3;

  // Handy fixed-point constants derived from the fraction width
  localparam fixed_t FIX_ONE  = fixed_t'(1) << FRAC_BITS;
  localparam fixed_t FIX_HALF = fixed_t'(1) << (FRAC_BITS - 1);
  localparam fixed_t FIX_ZERO = '0;

  // Start-up view. The player stands in the middle of map cell (1,1),
  // faces (0,1) and has a view plane of (-0.5,0), which is a narrow
  // field of view but keeps the arithmetic simple
  localparam pov_t POV_RESET = '{
    player: '{x: FIX_ONE + FIX_HALF, y: FIX_ONE + FIX_HALF},
    facing: '{x: FIX_ZERO,           y: FIX_ONE},
    vplane: '{x: -FIX_HALF,          y: FIX_ZERO}
  };

endpackage
